// File: wci_params.svh
/*
  WCI link parameters
  Widths, request FIFO depth, property count and control-op latency
*/
`ifndef WCI_PARAMS_SVH
`define WCI_PARAMS_SVH

// OCP signal widths
`define WCI_ADDR_W 20
`define WCI_DATA_W 32
`define WCI_BE_W 4

`define WCI_REQ_DEPTH 2   // Request FIFO entries, also host starting credits
`define WCI_NUM_PROPS 16  // Configuration property words
`define WCI_CTL_LAT 4     // Cycles from control command to response
`define WCI_CNT_W 16      // Monitor counter width

`endif

// File: wciPkg.sv
/*
  WCI link types
  OCP command and response codes, worker life-cycle states, control ops
*/
package wciPkg;

  // OCP MCmd encoding
  typedef enum logic [2:0] {
    CMD_IDLE = 3'd0,
    CMD_WR   = 3'd1,
    CMD_RD   = 3'd2
  } ocpCmdT;

  // OCP SResp encoding
  typedef enum logic [1:0] {
    RESP_NULL = 2'd0,
    RESP_DVA  = 2'd1,  // Data valid / accepted
    RESP_FAIL = 2'd2,
    RESP_ERR  = 2'd3
  } ocpRespT;

  // Worker life-cycle states
  typedef enum logic [2:0] {
    ST_EXISTS      = 3'd0,
    ST_INITIALIZED = 3'd1,
    ST_OPERATING   = 3'd2,
    ST_SUSPENDED   = 3'd3,
    ST_UNUSABLE    = 3'd4
  } wciStateT;

  // Control op, from MAddr[4:2] of a control-space read
  typedef enum logic [2:0] {
    OP_INIT    = 3'd0,
    OP_START   = 3'd1,
    OP_STOP    = 3'd2,
    OP_RELEASE = 3'd3
  } wciCtlOpT;

endpackage

// File: wciInitiator.sv
/*
  WCI initiator
  Queues host requests with credit return, issues one OCP command at a time,
  returns responses in order and generates the link reset
*/
`timescale 1ns/1ps
`include "wci_params.svh"

module wciInitiator (
  input  logic                   CLK,
  input  logic                   arstN,
  input  logic                   reqValid,
  input  logic                   reqWrite,
  input  logic                   reqSpace,     // 0 control, 1 configuration
  input  logic [`WCI_ADDR_W-1:0] reqAddr,
  input  logic [`WCI_BE_W-1:0]   reqByteEn,
  input  logic [`WCI_DATA_W-1:0] reqData,
  output logic                   reqCredit,
  output logic                   respValid,
  output wciPkg::ocpRespT        respCode,
  output logic [`WCI_DATA_W-1:0] respData,
  output logic                   MResetN,
  output wciPkg::ocpCmdT         MCmd,
  output logic                   MAddrSpace,
  output logic [`WCI_ADDR_W-1:0] MAddr,
  output logic [`WCI_BE_W-1:0]   MByteEn,
  output logic [`WCI_DATA_W-1:0] MData,
  input  wciPkg::ocpRespT        SResp,
  input  logic [`WCI_DATA_W-1:0] SData,
  input  logic                   SThreadBusy
);
  localparam int PTR_W = $clog2(`WCI_REQ_DEPTH);
  localparam int FILL_W = $clog2(`WCI_REQ_DEPTH + 1);

  logic [1:0]             rstSync;      // Link reset stretcher
  logic [PTR_W-1:0]       wrPtr;
  logic [PTR_W-1:0]       rdPtr;
  logic [FILL_W-1:0]      fillCnt;
  logic                   outstanding;  // Command issued, SResp pending
  logic                   issue;
  logic                   fifoWrite [`WCI_REQ_DEPTH];
  logic                   fifoSpace [`WCI_REQ_DEPTH];
  logic [`WCI_ADDR_W-1:0] fifoAddr [`WCI_REQ_DEPTH];
  logic [`WCI_BE_W-1:0]   fifoBe [`WCI_REQ_DEPTH];
  logic [`WCI_DATA_W-1:0] fifoData [`WCI_REQ_DEPTH];

  // MResetN follows arstN low, releases 2 cycles later
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) rstSync <= '0;
    else        rstSync <= {rstSync[0], 1'b1};
  end
  assign MResetN = rstSync[1];

  // Head goes out when link is up, free and target not busy
  assign issue = (fillCnt != '0) && !outstanding && !SThreadBusy && MResetN;

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      fillCnt     <= '0;
      outstanding <= 1'b0;
      reqCredit   <= 1'b0;
      respValid   <= 1'b0;
      MCmd        <= wciPkg::CMD_IDLE;
    end else begin
      if (reqValid)
        wrPtr <= (wrPtr == PTR_W'(`WCI_REQ_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (issue)
        rdPtr <= (rdPtr == PTR_W'(`WCI_REQ_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      fillCnt   <= fillCnt + FILL_W'(reqValid) - FILL_W'(issue);
      reqCredit <= issue;  // One credit back per dequeue
      MCmd      <= issue ? (fifoWrite[rdPtr] ? wciPkg::CMD_WR : wciPkg::CMD_RD)
                         : wciPkg::CMD_IDLE;
      if (issue)                               outstanding <= 1'b1;
      else if (SResp != wciPkg::RESP_NULL)     outstanding <= 1'b0;
      respValid <= (SResp != wciPkg::RESP_NULL);  // Registered response pulse
    end
  end

  // FIFO storage, command payload and response payload
  always_ff @(posedge CLK) begin
    if (reqValid) begin
      fifoWrite[wrPtr] <= reqWrite;
      fifoSpace[wrPtr] <= reqSpace;
      fifoAddr[wrPtr]  <= reqAddr;
      fifoBe[wrPtr]    <= reqByteEn;
      fifoData[wrPtr]  <= reqData;
    end
    if (issue) begin
      MAddrSpace <= fifoSpace[rdPtr];
      MAddr      <= fifoAddr[rdPtr];
      MByteEn    <= fifoBe[rdPtr];
      MData      <= fifoData[rdPtr];
    end
    respCode <= SResp;
    respData <= SData;
  end

  // Host must hold a credit for every request
  assert property (@(posedge CLK) disable iff (!arstN)
    reqValid |-> (fillCnt < FILL_W'(`WCI_REQ_DEPTH)))
    else $error("Request enqueued into a full FIFO");

  // Target answers only issued commands
  assert property (@(posedge CLK) disable iff (!MResetN)
    (SResp != wciPkg::RESP_NULL) |-> outstanding)
    else $error("SResp with no command outstanding");

endmodule

// File: wciTarget.sv
/*
  WCI worker target
  Control space runs the life-cycle FSM with a busy period,
  configuration space is a byte-enabled property register file
*/
`timescale 1ns/1ps
`include "wci_params.svh"

module wciTarget (
  input  logic                   CLK,
  input  logic                   MResetN,
  input  wciPkg::ocpCmdT         MCmd,
  input  logic                   MAddrSpace,  // 0 control, 1 configuration
  input  logic [`WCI_ADDR_W-1:0] MAddr,
  input  logic [`WCI_BE_W-1:0]   MByteEn,
  input  logic [`WCI_DATA_W-1:0] MData,
  output wciPkg::ocpRespT        SResp,
  output logic [`WCI_DATA_W-1:0] SData,
  output logic                   SThreadBusy
);
  localparam int BUSY_W = $clog2(`WCI_CTL_LAT + 1);
  localparam int IDX_W = $clog2(`WCI_NUM_PROPS);

  logic [`WCI_DATA_W-1:0] props [`WCI_NUM_PROPS];  // Property words
  wciPkg::wciStateT       state;
  wciPkg::wciStateT       nextState;
  wciPkg::wciCtlOpT       ctlOp;     // Op latched for the busy period
  logic [BUSY_W-1:0]      busyCnt;
  logic                   ctlLegal;
  logic                   cmdValid;
  logic                   ctlStart;
  logic                   cfgHit;
  logic                   cfgWrOk;
  logic                   ctlDone;
  logic [IDX_W-1:0]       propIdx;

  assign cmdValid = (MCmd != wciPkg::CMD_IDLE);
  assign propIdx  = MAddr[IDX_W+1:2];
  assign cfgHit   = MAddr[`WCI_ADDR_W-1:2] < (`WCI_ADDR_W - 2)'(`WCI_NUM_PROPS);
  assign cfgWrOk  = (state == wciPkg::ST_INITIALIZED) || (state == wciPkg::ST_OPERATING) ||
                    (state == wciPkg::ST_SUSPENDED);
  // Control read with op 0..3 starts a slow op; 4..7 is an error
  assign ctlStart = (MCmd == wciPkg::CMD_RD) && !MAddrSpace && !MAddr[4];
  assign ctlDone  = (busyCnt == BUSY_W'(1));

  // Life-cycle transition rules
  always_comb begin
    nextState = state;
    ctlLegal  = 1'b0;
    case (ctlOp)
      wciPkg::OP_INIT: if (state == wciPkg::ST_EXISTS) begin
        nextState = wciPkg::ST_INITIALIZED;
        ctlLegal  = 1'b1;
      end
      wciPkg::OP_START:
        if (state == wciPkg::ST_INITIALIZED || state == wciPkg::ST_SUSPENDED) begin
          nextState = wciPkg::ST_OPERATING;
          ctlLegal  = 1'b1;
        end
      wciPkg::OP_STOP: if (state == wciPkg::ST_OPERATING) begin
        nextState = wciPkg::ST_SUSPENDED;
        ctlLegal  = 1'b1;
      end
      wciPkg::OP_RELEASE: if (state != wciPkg::ST_UNUSABLE) begin
        nextState = wciPkg::ST_UNUSABLE;
        ctlLegal  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK or negedge MResetN) begin
    if (!MResetN) begin
      state       <= wciPkg::ST_EXISTS;
      SResp       <= wciPkg::RESP_NULL;
      SThreadBusy <= 1'b0;
      busyCnt     <= '0;
    end else begin
      SResp <= wciPkg::RESP_NULL;  // Single-cycle response
      if (busyCnt != '0) begin
        busyCnt <= busyCnt - 1'b1;
        if (ctlDone) begin         // Control op completes
          SThreadBusy <= 1'b0;
          SResp       <= ctlLegal ? wciPkg::RESP_DVA : wciPkg::RESP_FAIL;
          if (ctlLegal) state <= nextState;
        end
      end else if (ctlStart) begin
        busyCnt     <= BUSY_W'(`WCI_CTL_LAT - 1);
        SThreadBusy <= 1'b1;
      end else if (cmdValid) begin
        if (!MAddrSpace || !cfgHit)                      SResp <= wciPkg::RESP_ERR;
        else if ((MCmd == wciPkg::CMD_WR) && !cfgWrOk)   SResp <= wciPkg::RESP_FAIL;
        else                                             SResp <= wciPkg::RESP_DVA;
      end
    end
  end

  // Register file, response data and latched op
  always_ff @(posedge CLK) begin
    if (ctlStart) ctlOp <= wciPkg::wciCtlOpT'(MAddr[4:2]);
    if (ctlDone)
      SData <= (`WCI_DATA_W)'(nextState);  // Resulting state, unchanged on FAIL
    else if (cmdValid && MAddrSpace && cfgHit && (MCmd == wciPkg::CMD_RD))
      SData <= props[propIdx];
    else if (cmdValid)
      SData <= '0;
    if (cmdValid && MAddrSpace && cfgHit && (MCmd == wciPkg::CMD_WR) && cfgWrOk) begin
      for (int i = 0; i < `WCI_BE_W; i++) begin
        if (MByteEn[i]) props[propIdx][8*i +: 8] <= MData[8*i +: 8];  // Byte merge
      end
    end
  end

  // Initiator must hold off while a control op runs
  assert property (@(posedge CLK) disable iff (!MResetN)
    SThreadBusy |-> (MCmd == wciPkg::CMD_IDLE))
    else $error("Command issued while SThreadBusy");

endmodule

// File: wciMonitor.sv
/*
  WCI link monitor
  Passively tracks the outstanding command, counts completions
  and raises a sticky flag on OCP protocol violations
*/
`timescale 1ns/1ps
`include "wci_params.svh"

module wciMonitor (
  input  logic                  CLK,
  input  logic                  MResetN,
  input  wciPkg::ocpCmdT        MCmd,
  input  logic                  MAddrSpace,
  input  wciPkg::ocpRespT       SResp,
  input  logic                  SThreadBusy,
  output logic [`WCI_CNT_W-1:0] wrCount,
  output logic [`WCI_CNT_W-1:0] rdCount,
  output logic [`WCI_CNT_W-1:0] failCount,
  output logic [`WCI_CNT_W-1:0] errCount,
  output logic                  protocolErr
);
  logic outstanding;  // Own view of the pending command
  logic outWrite;
  logic outCtl;       // Pending command targets control space
  logic cmdPrev;
  logic cmdValid;
  logic respSeen;
  logic violation;

  assign cmdValid = (MCmd != wciPkg::CMD_IDLE);
  assign respSeen = (SResp != wciPkg::RESP_NULL);

  always_comb begin
    violation = 1'b0;
    if (cmdValid && (SThreadBusy || outstanding)) violation = 1'b1;  // Issued into busy link
    if (respSeen && !outstanding)                  violation = 1'b1;  // Orphan response
    if (cmdValid && cmdPrev)                       violation = 1'b1;  // MCmd held 2 cycles
    // Busy only belongs to a pending control op
    if (SThreadBusy && !(outstanding && outCtl))   violation = 1'b1;
  end

  always_ff @(posedge CLK or negedge MResetN) begin
    if (!MResetN) begin
      outstanding <= 1'b0;
      outWrite    <= 1'b0;
      outCtl      <= 1'b0;
      cmdPrev     <= 1'b0;
      wrCount     <= '0;
      rdCount     <= '0;
      failCount   <= '0;
      errCount    <= '0;
      protocolErr <= 1'b0;
    end else begin
      cmdPrev <= cmdValid;
      if (cmdValid) begin
        outstanding <= 1'b1;
        outWrite    <= (MCmd == wciPkg::CMD_WR);
        outCtl      <= !MAddrSpace;
      end else if (respSeen) begin
        outstanding <= 1'b0;
      end
      if (respSeen && outstanding) begin  // Completion of the pending command
        if (outWrite) wrCount <= wrCount + 1'b1;
        else          rdCount <= rdCount + 1'b1;
        if (SResp == wciPkg::RESP_FAIL) failCount <= failCount + 1'b1;
        if (SResp == wciPkg::RESP_ERR)  errCount  <= errCount + 1'b1;
      end
      if (violation) protocolErr <= 1'b1;  // Sticky until link reset
    end
  end

endmodule

// File: wciSubsystem.sv
/*
  WCI subsystem top level
  Initiator, worker target and monitor on one internal OCP link
*/
`timescale 1ns/1ps
`include "wci_params.svh"

module wciSubsystem (
  input  logic                   CLK,
  input  logic                   arstN,
  input  logic                   reqValid,
  input  logic                   reqWrite,
  input  logic                   reqSpace,
  input  logic [`WCI_ADDR_W-1:0] reqAddr,
  input  logic [`WCI_BE_W-1:0]   reqByteEn,
  input  logic [`WCI_DATA_W-1:0] reqData,
  output logic                   reqCredit,
  output logic                   respValid,
  output wciPkg::ocpRespT        respCode,
  output logic [`WCI_DATA_W-1:0] respData,
  output logic [`WCI_CNT_W-1:0]  wrCount,
  output logic [`WCI_CNT_W-1:0]  rdCount,
  output logic [`WCI_CNT_W-1:0]  failCount,
  output logic [`WCI_CNT_W-1:0]  errCount,
  output logic                   protocolErr
);
  // OCP link, shared by all three blocks
  logic                   MResetN;
  wciPkg::ocpCmdT         MCmd;
  logic                   MAddrSpace;
  logic [`WCI_ADDR_W-1:0] MAddr;
  logic [`WCI_BE_W-1:0]   MByteEn;
  logic [`WCI_DATA_W-1:0] MData;
  wciPkg::ocpRespT        SResp;
  logic [`WCI_DATA_W-1:0] SData;
  logic                   SThreadBusy;

  wciInitiator initiator (  // Host side, drives the link and its reset
    .CLK, .arstN, .reqValid, .reqWrite, .reqSpace, .reqAddr, .reqByteEn, .reqData,
    .reqCredit, .respValid, .respCode, .respData,
    .MResetN, .MCmd, .MAddrSpace, .MAddr, .MByteEn, .MData,
    .SResp, .SData, .SThreadBusy
  );

  wciTarget target (  // Worker under control
    .CLK, .MResetN, .MCmd, .MAddrSpace, .MAddr, .MByteEn, .MData,
    .SResp, .SData, .SThreadBusy
  );

  wciMonitor monitor (  // Observer only
    .CLK, .MResetN, .MCmd, .MAddrSpace, .SResp, .SThreadBusy,
    .wrCount, .rdCount, .failCount, .errCount, .protocolErr
  );

endmodule

// File: wciSubsystemTb.sv
/*
  WCI subsystem testbench
  Credit-gated host stimulus, reference model of the worker state and
  property words, concurrent assertions on every response
*/
`timescale 1ns/1ps
`include "wci_params.svh"

module wciSubsystemTb;
  localparam int NUM_RAND = 12;                 // Random write and read-back pairs
  localparam int NUM_REQS = 34 + 2 * NUM_RAND;  // Fixed parts plus random pairs
  localparam int WATCHDOG_CYCLES = NUM_REQS * (`WCI_CTL_LAT + 8) + 200;

  logic                   CLK;
  logic                   arstN;
  logic                   reqValid;
  logic                   reqWrite;
  logic                   reqSpace;
  logic [`WCI_ADDR_W-1:0] reqAddr;
  logic [`WCI_BE_W-1:0]   reqByteEn;
  logic [`WCI_DATA_W-1:0] reqData;
  logic                   reqCredit;
  logic                   respValid;
  wciPkg::ocpRespT        respCode;
  logic [`WCI_DATA_W-1:0] respData;
  logic [`WCI_CNT_W-1:0]  wrCount;
  logic [`WCI_CNT_W-1:0]  rdCount;
  logic [`WCI_CNT_W-1:0]  failCount;
  logic [`WCI_CNT_W-1:0]  errCount;
  logic                   protocolErr;

  // Expected responses in request order, 6-bit pointers wrap
  wciPkg::ocpRespT        expCode [64];
  logic [`WCI_DATA_W-1:0] expData [64];
  logic                   expChk [64];  // Data known, so compared
  logic [5:0]             expWr;
  logic [5:0]             expRd;

  wciPkg::wciStateT       mState;                   // Model worker state
  logic [`WCI_DATA_W-1:0] mProps [`WCI_NUM_PROPS];
  logic [`WCI_BE_W-1:0]   mKnown [`WCI_NUM_PROPS];  // Bytes written legally so far

  int seed;
  int failures;
  int spent;        // Credits used
  int creditsBack;  // reqCredit pulses seen
  int credits;
  int tallyWr;
  int tallyRd;
  int tallyFail;
  int tallyErr;

  assign credits = `WCI_REQ_DEPTH - spent + creditsBack;

  wciSubsystem DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout: %0d responses still missing after %0d cycles",
             expWr - expRd, WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  // Pop on each response, count returned credits
  always @(posedge CLK) begin
    if (!arstN) begin
      expRd       <= '0;
      creditsBack <= 0;
    end else begin
      if (respValid) expRd <= expRd + 6'd1;
      if (reqCredit) creditsBack <= creditsBack + 1;
    end
  end

  task automatic flagError(input string msg);
    failures++;
    $display("Fail at %0d ns: %s", $time, msg);
  endtask

  assert property (@(posedge CLK) disable iff (!arstN) respValid |-> (expRd != expWr))
    else flagError("response with no request outstanding");
  assert property (@(posedge CLK) disable iff (!arstN)
    respValid |-> (respCode == expCode[expRd]))
    else flagError("response code differs from the model");
  assert property (@(posedge CLK) disable iff (!arstN)
    (respValid && expChk[expRd]) |-> (respData == expData[expRd]))
    else flagError("response data differs from the model");
  assert property (@(posedge CLK) disable iff (!arstN)
    (credits >= 0) && (credits <= `WCI_REQ_DEPTH))
    else flagError("host credit count out of range");
  assert property (@(posedge CLK) disable iff (!arstN) !$rose(protocolErr))
    else flagError("monitor raised protocolErr");

  // Expected response from the life-cycle and property rules, model updated in order
  task automatic predictResponse(input logic wr, input logic space,
                                 input logic [`WCI_ADDR_W-1:0] addr,
                                 input logic [`WCI_BE_W-1:0] be,
                                 input logic [`WCI_DATA_W-1:0] data,
                                 output wciPkg::ocpRespT code,
                                 output logic [`WCI_DATA_W-1:0] rdata, output logic chk);
    wciPkg::wciStateT nxt;
    int idx;
    idx   = addr[5:2];
    rdata = '0;
    chk   = 1'b0;
    nxt   = mState;
    if (!space) begin
      if (wr || addr[4]) begin
        code = wciPkg::RESP_ERR;  // Control write or op 4..7
      end else begin
        case (addr[4:2])
          wciPkg::OP_INIT: if (mState == wciPkg::ST_EXISTS) nxt = wciPkg::ST_INITIALIZED;
          wciPkg::OP_START:
            if (mState inside {wciPkg::ST_INITIALIZED, wciPkg::ST_SUSPENDED})
              nxt = wciPkg::ST_OPERATING;
          wciPkg::OP_STOP: if (mState == wciPkg::ST_OPERATING) nxt = wciPkg::ST_SUSPENDED;
          default: if (mState != wciPkg::ST_UNUSABLE) nxt = wciPkg::ST_UNUSABLE;  // Release
        endcase
        // Every legal transition changes the state
        code   = (nxt != mState) ? wciPkg::RESP_DVA : wciPkg::RESP_FAIL;
        mState = nxt;
        rdata  = (`WCI_DATA_W)'(nxt);
        chk    = 1'b1;
      end
    end else if (addr[`WCI_ADDR_W-1:2] >= `WCI_NUM_PROPS) begin
      code = wciPkg::RESP_ERR;
    end else if (wr) begin
      if (mState inside {wciPkg::ST_INITIALIZED, wciPkg::ST_OPERATING, wciPkg::ST_SUSPENDED})
      begin
        for (int b = 0; b < `WCI_BE_W; b++) begin
          if (be[b]) mProps[idx][8*b +: 8] = data[8*b +: 8];
        end
        mKnown[idx] = mKnown[idx] | be;
        code = wciPkg::RESP_DVA;
      end else begin
        code = wciPkg::RESP_FAIL;  // Word left alone
      end
    end else begin
      code  = wciPkg::RESP_DVA;
      rdata = mProps[idx];
      chk   = &mKnown[idx];
    end
    if (wr) tallyWr++;
    else    tallyRd++;
    if (code == wciPkg::RESP_FAIL) tallyFail++;
    if (code == wciPkg::RESP_ERR)  tallyErr++;
  endtask

  // One request on a falling edge, only while a credit is held
  task automatic sendReq(input logic wr, input logic space, input logic [`WCI_ADDR_W-1:0] addr,
                         input logic [`WCI_BE_W-1:0] be, input logic [`WCI_DATA_W-1:0] data);
    wciPkg::ocpRespT        code;
    logic [`WCI_DATA_W-1:0] rdata;
    logic                   chk;
    while (credits <= 0) @(negedge CLK);
    predictResponse(wr, space, addr, be, data, code, rdata, chk);
    expCode[expWr] = code;
    expData[expWr] = rdata;
    expChk[expWr]  = chk;
    expWr          = expWr + 6'd1;
    reqValid  = 1'b1;
    reqWrite  = wr;
    reqSpace  = space;
    reqAddr   = addr;
    reqByteEn = be;
    reqData   = data;
    spent++;
    @(negedge CLK);
    reqValid = 1'b0;
  endtask

  task automatic runCtlOp(input wciPkg::wciCtlOpT op);
    sendReq(1'b0, 1'b0, (`WCI_ADDR_W)'({op, 2'b00}), 4'hF, '0);
  endtask

  task automatic writeProp(input int word, input logic [`WCI_BE_W-1:0] be,
                           input logic [`WCI_DATA_W-1:0] data);
    sendReq(1'b1, 1'b1, (`WCI_ADDR_W)'(word << 2), be, data);
  endtask

  task automatic readProp(input int word);
    sendReq(1'b0, 1'b1, (`WCI_ADDR_W)'(word << 2), 4'hF, '0);
  endtask

  // Burst is over once every expected response has arrived
  task automatic waitIdle;
    while (expRd != expWr) @(negedge CLK);
    @(negedge CLK);
    assert (credits == `WCI_REQ_DEPTH)
      else flagError($sformatf("%0d credits after burst, expected %0d", credits,
                               `WCI_REQ_DEPTH));
  endtask

  initial begin
    int                   word;
    logic [`WCI_BE_W-1:0] be;
    seed      = 32'h626e;
    arstN     = 1'b0;
    reqValid  = 1'b0;
    reqWrite  = 1'b0;
    reqSpace  = 1'b0;
    reqAddr   = '0;
    reqByteEn = '0;
    reqData   = '0;
    failures  = 0;
    spent     = 0;
    tallyWr   = 0;
    tallyRd   = 0;
    tallyFail = 0;
    tallyErr  = 0;
    expWr     = '0;
    mState    = wciPkg::ST_EXISTS;
    for (int i = 0; i < `WCI_NUM_PROPS; i++) mKnown[i] = '0;
    repeat (10) @(negedge CLK);
    arstN = 1'b1;

    runCtlOp(wciPkg::OP_START);           // Illegal from exists
    writeProp(3, 4'hF, $random(seed));    // Not initialized yet
    readProp(3);
    runCtlOp(wciPkg::OP_INIT);
    runCtlOp(wciPkg::OP_START);
    waitIdle();

    for (int i = 0; i < 8; i++) writeProp(i, 4'hF, $random(seed));  // Whole words first
    for (int i = 0; i < NUM_RAND; i++) begin
      word = $random(seed) & 7;
      be   = (`WCI_BE_W)'($random(seed));
      writeProp(word, be, $random(seed));  // Byte merge
      readProp(word);
    end
    waitIdle();

    sendReq(1'b1, 1'b0, '0, 4'hF, $random(seed));  // Control-space write
    for (int op = 4; op < 8; op++) sendReq(1'b0, 1'b0, (`WCI_ADDR_W)'(op << 2), 4'hF, '0);
    readProp(16);
    writeProp(20, 4'hF, $random(seed));
    readProp(32'h1000);                   // Far above the register file
    waitIdle();

    // Slow control ops mixed into full-credit bursts
    runCtlOp(wciPkg::OP_STOP);
    writeProp(2, (`WCI_BE_W)'($random(seed)), $random(seed));
    readProp(2);
    runCtlOp(wciPkg::OP_START);
    readProp(5);
    runCtlOp(wciPkg::OP_STOP);
    runCtlOp(wciPkg::OP_STOP);            // Already suspended
    runCtlOp(wciPkg::OP_START);
    runCtlOp(wciPkg::OP_RELEASE);
    writeProp(1, 4'hF, $random(seed));    // Unusable, word must survive
    readProp(1);
    runCtlOp(wciPkg::OP_START);
    runCtlOp(wciPkg::OP_RELEASE);
    waitIdle();

    assert (wrCount == (`WCI_CNT_W)'(tallyWr))
      else flagError($sformatf("wrCount %0d, expected %0d", wrCount, tallyWr));
    assert (rdCount == (`WCI_CNT_W)'(tallyRd))
      else flagError($sformatf("rdCount %0d, expected %0d", rdCount, tallyRd));
    assert (failCount == (`WCI_CNT_W)'(tallyFail))
      else flagError($sformatf("failCount %0d, expected %0d", failCount, tallyFail));
    assert (errCount == (`WCI_CNT_W)'(tallyErr))
      else flagError($sformatf("errCount %0d, expected %0d", errCount, tallyErr));
    assert (!protocolErr)
      else flagError("protocolErr set at end of run");

    $display("Done: %0d requests, %0d writes, %0d reads, %0d FAIL, %0d ERR, %0d errors",
             spent, tallyWr, tallyRd, tallyFail, tallyErr, failures);
    if (failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: wciSubsystem.f
+incdir+.
wciPkg.sv
wciInitiator.sv
wciTarget.sv
wciMonitor.sv
wciSubsystem.sv
wciSubsystemTb.sv

// File: run.sh
#!/bin/sh
# Build and run the WCI subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module wciSubsystemTb -f wciSubsystem.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/VwciSubsystemTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
echo "Pass message not found"
exit 1
